// File: Makefile
VERILATOR ?= verilator
TOP       ?= exuTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: rtl/aluUnit.sv
/*
  Operand select and 64-bit ALU, purely combinational.
  Shifts use the low 6 bits of operand B.
  slt/sltu give 0 or 1; passB forwards operand B (lui).
*/
`timescale 1ns/100ps
`include "exu_defines.svh"

module aluUnit import exu_pkg::*; (
    input  exuOp_t           op,
    input  logic [`XLEN-1:0] rs1Val,
    input  logic [`XLEN-1:0] rs2Val,
    output logic [`XLEN-1:0] result,
    output logic             zero
);

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [5:0]       shamt;

    assign opA = (op.srcA == srcAPc) ? op.pc : rs1Val;

    always_comb begin
        case (op.srcB)
            srcBImm:  opB = op.imm;
            srcBFour: opB = `XLEN'd4;
            default:  opB = rs2Val;
        endcase
    end

    assign shamt = opB[5:0];

    always_comb begin
        case (op.aluOp)
            aluAdd:   result = opA + opB;
            aluSub:   result = opA - opB;
            aluAnd:   result = opA & opB;
            aluOr:    result = opA | opB;
            aluXor:   result = opA ^ opB;
            aluSll:   result = opA << shamt;
            aluSrl:   result = opA >> shamt;
            aluSra:   result = $signed(opA) >>> shamt;
            aluSlt:   result = {63'd0, $signed(opA) < $signed(opB)};
            aluSltu:  result = {63'd0, opA < opB};
            aluPassB: result = opB;
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: rtl/csrUnit.sv
/*
  Machine CSR file: mscratch, mepc and mtvec only.
  Address is imm[11:0]; other addresses read zero, writes ignored.
  On ecall the write strobe stores pc into mepc instead of a CSR op.
  mret does not touch any CSR.
*/
`timescale 1ns/100ps
`include "exu_defines.svh"

module csrUnit import exu_pkg::*; (
    input  logic             clk,
    input  logic             rstN,
    input  exuOp_t           op,
    input  logic [`XLEN-1:0] rs1Val,
    input  logic             we,
    output logic [`XLEN-1:0] csrOld,
    output logic [`XLEN-1:0] mepc,
    output logic [`XLEN-1:0] mtvec
);

    logic [`CSR_AW-1:0] addr;
    logic [`XLEN-1:0]   mscratch;
    logic [`XLEN-1:0]   newVal;

    assign addr = op.imm[`CSR_AW-1:0];

    always_comb begin
        case (addr)
            `CSR_MSCRATCH: csrOld = mscratch;
            `CSR_MEPC:     csrOld = mepc;
            `CSR_MTVEC:    csrOld = mtvec;
            default:       csrOld = '0;
        endcase
    end

    // read-modify-write value
    always_comb begin
        case (op.csrOp)
            csrRw:   newVal = rs1Val;
            csrRs:   newVal = csrOld | rs1Val;
            csrRc:   newVal = csrOld & ~rs1Val;
            default: newVal = csrOld;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mscratch <= '0;
            mepc     <= '0;
            mtvec    <= '0;
        end else if (we) begin
            if (op.sysOp == sysEcall) begin
                mepc <= op.pc;
            end else begin
                case (addr)
                    `CSR_MSCRATCH: mscratch <= newVal;
                    `CSR_MEPC:     mepc     <= newVal;
                    `CSR_MTVEC:    mtvec    <= newVal;
                    default:       ;
                endcase
            end
        end
    end

endmodule

// File: rtl/exuCtrl.sv
/*
  Four-phase req/ack control for the execute stage.
  One instruction at a time: latched in idle, committed on the
  exec-to-done edge, released when req drops.
  op must be stable while req is high and ack is low.
*/
`timescale 1ns/100ps

module exuCtrl import exu_pkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       req,
    output logic       ack,
    input  exuOp_t     op,
    output exuOp_t     opReg,
    output logic       regWe,
    output logic       csrWe,
    input  exuResult_t resIn,
    output exuResult_t res
);

    ctrlState_e state;
    logic       commit;

    // exec lasts exactly one cycle
    assign commit = (state == stExec);
    assign regWe  = commit && opReg.regWen;
    assign csrWe  = commit && ((opReg.csrOp != csrNone) || (opReg.sysOp == sysEcall));
    assign ack    = (state == stDone);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: if (req) state <= stExec;
                stExec: state <= stDone;
                stDone: if (!req) state <= stIdle;
                default: state <= stIdle;
            endcase
        end
    end

    // bundle held for the datapath until the next acceptance
    always_ff @(posedge clk) begin
        if (state == stIdle && req) begin
            opReg <= op;
        end
    end

    // result frozen through the ack phase
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            res <= '0;
        end else if (commit) begin
            res <= resIn;
        end
    end

endmodule

// File: rtl/exuTop.sv
/*
  Execute stage top: control plus register file, ALU,
  next-pc and CSR datapath.
  Four-phase req/ack; one instruction in flight.
  No loads/stores, mul/div, word ops or interrupts.
*/
`timescale 1ns/100ps
`include "exu_defines.svh"

module exuTop import exu_pkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       req,
    output logic       ack,
    input  exuOp_t     op,
    output exuResult_t res
);

    exuOp_t           opReg;
    logic             regWe;
    logic             csrWe;
    logic [`XLEN-1:0] rs1Val;
    logic [`XLEN-1:0] rs2Val;
    logic [`XLEN-1:0] aluRes;
    logic             zero;
    logic [`XLEN-1:0] dnpc;
    logic [`XLEN-1:0] csrOld;
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] mtvec;
    exuResult_t       resIn;

    exuCtrl exuCtrl_i (
        .clk(clk), .rstN(rstN), .req(req), .ack(ack), .op(op), .opReg(opReg),
        .regWe(regWe), .csrWe(csrWe), .resIn(resIn), .res(res)
    );

    // writeback mux
    assign resIn.dnpc   = dnpc;
    assign resIn.wbData = opReg.toCsrReg ? csrOld : aluRes;

    regFile regFile_i (
        .clk(clk), .rstN(rstN), .raddrA(opReg.rs1), .raddrB(opReg.rs2),
        .waddr(opReg.rd), .wdata(resIn.wbData), .we(regWe),
        .rdataA(rs1Val), .rdataB(rs2Val)
    );

    aluUnit aluUnit_i (
        .op(opReg), .rs1Val(rs1Val), .rs2Val(rs2Val), .result(aluRes), .zero(zero)
    );

    nextPc nextPc_i (
        .op(opReg), .rs1Val(rs1Val), .aluRes(aluRes), .zero(zero),
        .mepc(mepc), .mtvec(mtvec), .dnpc(dnpc)
    );

    csrUnit csrUnit_i (
        .clk(clk), .rstN(rstN), .op(opReg), .rs1Val(rs1Val), .we(csrWe),
        .csrOld(csrOld), .mepc(mepc), .mtvec(mtvec)
    );

endmodule

// File: rtl/exu_defines.svh
/*
  Width and address constants for the RV64 execute stage.
  The design is fixed at RV64 with 32 integer registers.
  Only three machine CSRs exist; every other CSR address
  reads as zero and ignores writes.
*/
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// data path width
`define XLEN 64

// register file address width
`define REG_AW 5

// csr address width and the implemented addresses
`define CSR_AW 12
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC 12'h341
`define CSR_MTVEC 12'h305

`endif

// File: rtl/exu_pkg.sv
/*
  Types shared by the execute stage RTL and its testbench.
  exuOp_t is the decoded bundle handed over by fetch/decode.
  CSR address comes from imm[11:0], so imm must carry it for CSR ops.
*/
`include "exu_defines.svh"

package exu_pkg;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSll,
        aluSrl, aluSra, aluSlt, aluSltu, aluPassB
    } aluOp_e;

    typedef enum logic {srcARs1, srcAPc} srcA_e;
    typedef enum logic [1:0] {srcBRs2, srcBImm, srcBFour} srcB_e;

    typedef enum logic [2:0] {
        brNone, brJal, brJalr, brBeq, brBne, brBlt, brBge, brTrap
    } branch_e;

    typedef enum logic [1:0] {csrNone, csrRw, csrRs, csrRc} csrOp_e;
    typedef enum logic [1:0] {sysNone, sysEcall, sysMret} sysOp_e;

    // one decoded instruction
    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   imm;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rd;
        logic               regWen;
        aluOp_e             aluOp;
        srcA_e              srcA;
        srcB_e              srcB;
        branch_e            branch;
        csrOp_e             csrOp;
        sysOp_e             sysOp;
        logic               toCsrReg;
    } exuOp_t;

    typedef struct packed {
        logic [`XLEN-1:0] dnpc;
        logic [`XLEN-1:0] wbData;
    } exuResult_t;

    typedef enum logic [1:0] {stIdle, stExec, stDone} ctrlState_e;

endpackage

// File: rtl/nextPc.sv
/*
  Next-pc selection, purely combinational.
  beq/bne expect aluOp sub (uses zero); blt/bge expect aluOp slt
  (uses bit 0 of the ALU result). jalr target has bit 0 cleared.
*/
`timescale 1ns/100ps
`include "exu_defines.svh"

module nextPc import exu_pkg::*; (
    input  exuOp_t           op,
    input  logic [`XLEN-1:0] rs1Val,
    input  logic [`XLEN-1:0] aluRes,
    input  logic             zero,
    input  logic [`XLEN-1:0] mepc,
    input  logic [`XLEN-1:0] mtvec,
    output logic [`XLEN-1:0] dnpc
);

    logic [`XLEN-1:0] seqPc;
    logic [`XLEN-1:0] relPc;
    logic [`XLEN-1:0] jalrSum;

    assign seqPc   = op.pc + `XLEN'd4;
    assign relPc   = op.pc + op.imm;
    assign jalrSum = rs1Val + op.imm;

    always_comb begin
        case (op.branch)
            brJal:   dnpc = relPc;
            brJalr:  dnpc = {jalrSum[`XLEN-1:1], 1'b0};
            brBeq:   dnpc = zero ? relPc : seqPc;
            brBne:   dnpc = zero ? seqPc : relPc;
            brBlt:   dnpc = aluRes[0] ? relPc : seqPc;
            brBge:   dnpc = aluRes[0] ? seqPc : relPc;
            brTrap: begin
                // ecall to handler, mret back to saved pc
                case (op.sysOp)
                    sysEcall: dnpc = mtvec;
                    sysMret:  dnpc = mepc;
                    default:  dnpc = seqPc;
                endcase
            end
            default: dnpc = seqPc;
        endcase
    end

endmodule

// File: rtl/regFile.sv
/*
  32 x XLEN integer register file, two async reads, one write.
  x0 reads as zero; writes to it are dropped here.
  All registers clear on reset.
*/
`timescale 1ns/100ps
`include "exu_defines.svh"

module regFile (
    input  logic               clk,
    input  logic               rstN,
    input  logic [`REG_AW-1:0] raddrA,
    input  logic [`REG_AW-1:0] raddrB,
    input  logic [`REG_AW-1:0] waddr,
    input  logic [`XLEN-1:0]   wdata,
    input  logic               we,
    output logic [`XLEN-1:0]   rdataA,
    output logic [`XLEN-1:0]   rdataB
);

    logic [`XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

// File: sources.f
+incdir+rtl
rtl/exu_pkg.sv
rtl/exuCtrl.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/csrUnit.sv
rtl/nextPc.sv
rtl/exuTop.sv
test/exu_asserts.sv
test/exuTb.sv

// File: test/exuTb.sv
/*
  Testbench for the execute stage.
  Builds a table of bundles, computes expected results with its own
  register and CSR model, then runs each entry over the req/ack handshake.
  Operands come from $random with a fixed seed.
*/
`timescale 1ns/100ps
`include "exu_defines.svh"

module exuTb import exu_pkg::*; ;

    localparam int NT = 33;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_CYCLES = NT * 10 + RESET_CYCLES;

    logic       clk = 1'b0;
    logic       rstN;
    logic       req;
    logic       ack;
    exuOp_t     op;
    exuResult_t res;

    exuOp_t     ops [NT];
    exuResult_t expRes [NT];
    int         holdCycles [NT];

    // reference state
    logic [`XLEN-1:0] mRegs [32];
    logic [`XLEN-1:0] mScratch;
    logic [`XLEN-1:0] mEpc;
    logic [`XLEN-1:0] mTvec;

    int seed = 50195;
    int cycles = 0;
    int passCount = 0;
    int failCount = 0;

    exuTop exuTop_i (.clk(clk), .rstN(rstN), .req(req), .ack(ack), .op(op), .res(res));

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic exuOp_t buildOp(aluOp_e a, srcA_e sa, srcB_e sb, branch_e br,
                                       logic [4:0] rs1, logic [4:0] rs2, logic [4:0] rd,
                                       logic wen, logic [`XLEN-1:0] imm);
        exuOp_t o;
        o = '0;
        o.aluOp = a;
        o.srcA = sa;
        o.srcB = sb;
        o.branch = br;
        o.rs1 = rs1;
        o.rs2 = rs2;
        o.rd = rd;
        o.regWen = wen;
        o.imm = imm;
        return o;
    endfunction

    function automatic exuOp_t csrAccess(csrOp_e c, logic [4:0] rs1, logic [4:0] rd,
                                         logic [11:0] addr);
        exuOp_t o;
        o = buildOp(aluAdd, srcARs1, srcBRs2, brNone, rs1, 0, rd, 1'b1, {52'd0, addr});
        o.csrOp = c;
        o.toCsrReg = 1'b1;
        return o;
    endfunction

    function automatic exuOp_t trapOp(sysOp_e s);
        exuOp_t o;
        o = buildOp(aluAdd, srcARs1, srcBRs2, brTrap, 0, 0, 0, 1'b0, 64'd0);
        o.sysOp = s;
        return o;
    endfunction

    // executes one bundle on the model state and returns what the stage must report
    function automatic exuResult_t modelStep(exuOp_t o);
        logic [`XLEN-1:0] v1, v2, a, b, alu, old, nv;
        exuResult_t r;
        v1 = mRegs[o.rs1];
        v2 = mRegs[o.rs2];
        a = (o.srcA == srcAPc) ? o.pc : v1;
        b = (o.srcB == srcBImm) ? o.imm : ((o.srcB == srcBFour) ? 64'd4 : v2);
        case (o.aluOp)
            aluAdd:   alu = a + b;
            aluSub:   alu = a - b;
            aluAnd:   alu = a & b;
            aluOr:    alu = a | b;
            aluXor:   alu = a ^ b;
            aluSll:   alu = a << b[5:0];
            aluSrl:   alu = a >> b[5:0];
            aluSra:   alu = $signed(a) >>> b[5:0];
            aluSlt:   alu = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            aluSltu:  alu = (a < b) ? 64'd1 : 64'd0;
            aluPassB: alu = b;
            default:  alu = 64'd0;
        endcase
        case (o.imm[11:0])
            `CSR_MSCRATCH: old = mScratch;
            `CSR_MEPC:     old = mEpc;
            `CSR_MTVEC:    old = mTvec;
            default:       old = 64'd0;
        endcase
        r.wbData = o.toCsrReg ? old : alu;
        r.dnpc = o.pc + 64'd4;
        case (o.branch)
            brJal:   r.dnpc = o.pc + o.imm;
            brJalr:  r.dnpc = (v1 + o.imm) & ~64'd1;
            brBeq:   if (alu == 0) r.dnpc = o.pc + o.imm;
            brBne:   if (alu != 0) r.dnpc = o.pc + o.imm;
            brBlt:   if (alu[0]) r.dnpc = o.pc + o.imm;
            brBge:   if (!alu[0]) r.dnpc = o.pc + o.imm;
            brTrap:  if (o.sysOp == sysEcall) r.dnpc = mTvec;
                     else if (o.sysOp == sysMret) r.dnpc = mEpc;
            default: ;
        endcase
        nv = (o.csrOp == csrRw) ? v1 : ((o.csrOp == csrRs) ? (old | v1) : (old & ~v1));
        if (o.sysOp == sysEcall) begin
            mEpc = o.pc;
        end else if (o.csrOp != csrNone) begin
            case (o.imm[11:0])
                `CSR_MSCRATCH: mScratch = nv;
                `CSR_MEPC:     mEpc = nv;
                `CSR_MTVEC:    mTvec = nv;
                default:       ;
            endcase
        end
        if (o.regWen && o.rd != 0) mRegs[o.rd] = r.wbData;
        return r;
    endfunction

    task automatic fillTable();
        logic [`XLEN-1:0] r0, r1, r2;
        r0 = {$random(seed), $random(seed)};
        r1 = {$random(seed), $random(seed)};
        r2 = {$random(seed), $random(seed)};
        ops[0]  = buildOp(aluPassB, srcARs1, srcBImm, brNone, 0, 0, 1, 1'b1, r0);
        ops[1]  = buildOp(aluPassB, srcARs1, srcBImm, brNone, 0, 0, 2, 1'b1, r1);
        ops[2]  = buildOp(aluAdd, srcARs1, srcBRs2, brNone, 1, 2, 3, 1'b1, 64'd0);
        ops[3]  = buildOp(aluSub, srcARs1, srcBRs2, brNone, 1, 2, 4, 1'b1, 64'd0);
        ops[4]  = buildOp(aluAnd, srcARs1, srcBRs2, brNone, 1, 2, 5, 1'b1, 64'd0);
        ops[5]  = buildOp(aluOr, srcARs1, srcBRs2, brNone, 1, 2, 6, 1'b1, 64'd0);
        ops[6]  = buildOp(aluXor, srcARs1, srcBRs2, brNone, 1, 2, 7, 1'b1, 64'd0);
        ops[7]  = buildOp(aluSll, srcARs1, srcBRs2, brNone, 1, 2, 8, 1'b1, 64'd0);
        ops[8]  = buildOp(aluSrl, srcARs1, srcBRs2, brNone, 1, 2, 9, 1'b1, 64'd0);
        ops[9]  = buildOp(aluSra, srcARs1, srcBRs2, brNone, 1, 2, 10, 1'b1, 64'd0);
        ops[10] = buildOp(aluSlt, srcARs1, srcBRs2, brNone, 1, 2, 11, 1'b1, 64'd0);
        ops[11] = buildOp(aluSltu, srcARs1, srcBRs2, brNone, 1, 2, 12, 1'b1, 64'd0);
        // x0 write is dropped, then x0 read back through an add
        ops[12] = buildOp(aluPassB, srcARs1, srcBImm, brNone, 0, 0, 0, 1'b1, r2);
        ops[13] = buildOp(aluAdd, srcARs1, srcBRs2, brNone, 0, 1, 13, 1'b1, 64'd0);
        ops[14] = buildOp(aluSub, srcARs1, srcBRs2, brBeq, 1, 1, 0, 1'b0, 64'd16);
        ops[15] = buildOp(aluSub, srcARs1, srcBRs2, brBeq, 1, 2, 0, 1'b0, 64'd16);
        ops[16] = buildOp(aluSub, srcARs1, srcBRs2, brBne, 1, 2, 0, 1'b0, -64'sd8);
        ops[17] = buildOp(aluSlt, srcARs1, srcBRs2, brBlt, 1, 2, 0, 1'b0, 64'd12);
        ops[18] = buildOp(aluSlt, srcARs1, srcBRs2, brBge, 1, 2, 0, 1'b0, 64'd12);
        ops[19] = buildOp(aluAdd, srcAPc, srcBFour, brJal, 0, 0, 14, 1'b1, 64'h40);
        // odd jalr sum whatever x1 is
        ops[20] = buildOp(aluAdd, srcAPc, srcBFour, brJalr, 1, 0, 15, 1'b1,
                          r0[0] ? 64'd2 : 64'd1);
        ops[21] = csrAccess(csrRw, 1, 16, `CSR_MSCRATCH);
        ops[22] = csrAccess(csrRs, 2, 17, `CSR_MSCRATCH);
        ops[23] = csrAccess(csrRc, 1, 18, `CSR_MSCRATCH);
        ops[24] = csrAccess(csrRs, 1, 19, 12'h7c0);
        ops[25] = csrAccess(csrRw, 3, 0, `CSR_MTVEC);
        ops[26] = trapOp(sysEcall);
        ops[27] = csrAccess(csrRs, 0, 20, `CSR_MEPC);
        ops[28] = trapOp(sysMret);
        // req held high here, x21 must be written once
        ops[29] = buildOp(aluAdd, srcARs1, srcBImm, brNone, 21, 0, 21, 1'b1, r2);
        ops[30] = buildOp(aluAdd, srcARs1, srcBRs2, brNone, 21, 0, 22, 1'b1, 64'd0);
        // mscratch after the csrrc, then bne not taken
        ops[31] = csrAccess(csrRs, 0, 23, `CSR_MSCRATCH);
        ops[32] = buildOp(aluSub, srcARs1, srcBRs2, brBne, 1, 1, 0, 1'b0, -64'sd8);
        holdCycles[29] = 3;
        for (int i = 0; i < NT; i++) begin
            ops[i].pc = 64'h8000_0000 + (64'(i) << 2);
            expRes[i] = modelStep(ops[i]);
        end
    endtask

    task automatic compareRes(input int i, inout int errs);
        if (res.wbData !== expRes[i].wbData) begin
            $display("CHECK FAILED t=%0t test %0d res.wbData: got %h expected %h",
                     $time, i, res.wbData, expRes[i].wbData);
            errs++;
        end
        if (res.dnpc !== expRes[i].dnpc) begin
            $display("CHECK FAILED t=%0t test %0d res.dnpc: got %h expected %h",
                     $time, i, res.dnpc, expRes[i].dnpc);
            errs++;
        end
    endtask

    task automatic runTest(input int i);
        int lat;
        int errs;
        lat = 0;
        errs = 0;
        @(posedge clk);
        op <= ops[i];
        req <= 1'b1;
        @(negedge clk);
        while (!ack) begin
            lat++;
            @(negedge clk);
        end
        if (lat != 2) begin
            $display("CHECK FAILED t=%0t test %0d ack latency: got %0d expected 2",
                     $time, i, lat);
            errs++;
        end
        compareRes(i, errs);
        repeat (holdCycles[i]) begin
            @(negedge clk);
            if (ack !== 1'b1) begin
                $display("CHECK FAILED t=%0t test %0d ack during hold: got %b expected 1",
                         $time, i, ack);
                errs++;
            end
            compareRes(i, errs);
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        while (ack) @(negedge clk);
        if (errs == 0) passCount++;
        else failCount++;
        $display("test %0d %s", i, (errs == 0) ? "ok" : "FAILED");
    endtask

    initial begin
        rstN = 1'b0;
        req = 1'b0;
        op = '0;
        for (int k = 0; k < 32; k++) mRegs[k] = '0;
        mScratch = '0;
        mEpc = '0;
        mTvec = '0;
        fillTable();
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        if (ack !== 1'b0) begin
            $display("CHECK FAILED t=%0t after reset ack: got %b expected 0", $time, ack);
            failCount++;
        end
        for (int i = 0; i < NT; i++) runTest(i);
        $display("tests run %0d, passed %0d, failed %0d", NT, passCount, failCount);
        if (failCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: test/exu_asserts.sv
/*
  Handshake and reset assertions, bound into exuTop.
  regWe is the internal commit strobe of the register file.
*/
`timescale 1ns/100ps

module exuAsserts (
    input logic clk,
    input logic rstN,
    input logic req,
    input logic ack,
    input logic regWe
);

    ackRiseWithReq: assert property (@(posedge clk) disable iff (!rstN) $rose(ack) |-> req)
        else $error("ack rose while req was low");

    ackFallAfterReqLow: assert property (@(posedge clk) disable iff (!rstN)
        $fell(ack) |-> !$past(req))
        else $error("ack fell before req was dropped");

    // one commit per instruction
    regWeSingle: assert property (@(posedge clk) disable iff (!rstN) regWe |=> !regWe)
        else $error("regWe high for two cycles in a row");

    ackLowInReset: assert property (@(posedge clk) !rstN |-> !ack)
        else $error("ack high during reset");

endmodule

bind exuTop exuAsserts exuAsserts_i (
    .clk(clk), .rstN(rstN), .req(req), .ack(ack), .regWe(regWe)
);
